//--- run_sim.sh
#!/bin/sh
# Build the router testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module router_tb -f tb.f -o router_sim \
  > sim.log 2>&1 &&
  ./obj_dir/router_sim >> sim.log 2>&1 ||
  { cat sim.log; echo "Build or run error, see sim.log"; exit 1; }

cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

//--- source/flit_buffer.sv
/*
 * Single-entry elastic buffer
 * Holds one flit, refills in the same cycle it drains
 */
module flit_buffer (
  input  logic            clk,
  input  logic            reset,
  // Upstream side
  input  flit_pkg::flit_t in_flit,
  input  logic            in_valid,
  output logic            in_ready,
  // Downstream side
  input  logic            out_ready,
  output logic            out_valid,
  output flit_pkg::flit_t out_flit
);

  // Occupancy flag
  logic full;

  // Stored flit
  flit_pkg::flit_t data_q;

  // Handshake events of this cycle
  logic pop;
  logic push;

  // Downstream takes the held flit
  assign pop = full & out_ready;

  // Room when empty or when the held flit leaves now
  assign in_ready = ~full | pop;

  assign push = in_valid & in_ready;

  // Data is visible from the edge after the push
  assign out_valid = full;
  assign out_flit  = data_q;

  // --------------------------------------------------------------------------
  // Occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (push) begin
      // Push alone or push with pop, stays full either way
      full <= 1'b1;
    end else if (pop) begin
      full <= 1'b0;
    end
  end

  // Overwrite on every push
  // A steady stream moves one flit per cycle
  always_ff @(posedge clk) begin
    if (push) begin
      data_q <= in_flit;
    end
  end

endmodule

//--- source/flit_pkg.sv
/*
 * Flit format for the mesh router
 * Field widths, the 64-bit flit layout and the forward half of a channel
 */
package flit_pkg;

  // --------------------------------------------------------------------------
  // Field widths
  // --------------------------------------------------------------------------

  // Whole flit as it travels on a link
  localparam int FLIT_W = 64;

  // One hop counter, per axis
  localparam int HOP_W = 4;

  // Application payload at the bottom of the flit
  localparam int PAYLOAD_W = 48;

  // Reserved bits between the direction flags and the hop counters
  // Top reserved bit, x_dir and y_dir account for the 3
  localparam int RSVD_W = FLIT_W - 3 - 2 * HOP_W - PAYLOAD_W;

  // Remaining hops along one axis
  typedef logic [HOP_W-1:0] hop_t;

  // --------------------------------------------------------------------------
  // Flit layout, MSB first
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic                 rsvd_top;
    // 0 = right, 1 = left
    logic                 x_dir;
    // 0 = up, 1 = down
    logic                 y_dir;
    logic [RSVD_W-1:0]    rsvd;
    hop_t                 hop_x;
    hop_t                 hop_y;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // Forward half of a channel, ready travels back on its own wire
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

endpackage

//--- source/input_port.sv
/*
 * Router input port
 * Buffers one flit and routes it X then Y, updating the hop count
 */
module input_port (
  input  logic                   clk,
  input  logic                   reset,
  // Link from the neighbour or the core
  input  flit_pkg::link_t        in_link,
  output logic                   in_ready,
  // Per-output readies from the crossbar
  input  router_pkg::port_mask_t out_ready,
  // Requested output, one-hot, zero when empty
  output router_pkg::port_mask_t req,
  // Flit with the hop count for this hop taken off
  output flit_pkg::flit_t        fwd_flit
);

  // Buffered flit
  flit_pkg::flit_t buf_flit;
  logic            buf_valid;

  // Chosen output accepts the flit
  logic pop;

  flit_buffer i_in_buf (
    .clk       (clk),
    .reset     (reset),
    .in_flit   (in_link.flit),
    .in_valid  (in_link.valid),
    .in_ready  (in_ready),
    .out_ready (pop),
    .out_valid (buf_valid),
    .out_flit  (buf_flit)
  );

  // --------------------------------------------------------------------------
  // Dimension-order route
  // --------------------------------------------------------------------------
  // X hops first, Y after X is done, then local delivery
  always_comb begin
    req      = '0;
    fwd_flit = buf_flit;
    if (buf_valid) begin
      if (buf_flit.hop_x != '0) begin
        fwd_flit.hop_x = buf_flit.hop_x - flit_pkg::hop_t'(1);
        if (buf_flit.x_dir) begin
          req[router_pkg::PORT_LEFT] = 1'b1;
        end else begin
          req[router_pkg::PORT_RIGHT] = 1'b1;
        end
      end else if (buf_flit.hop_y != '0) begin
        fwd_flit.hop_y = buf_flit.hop_y - flit_pkg::hop_t'(1);
        if (buf_flit.y_dir) begin
          req[router_pkg::PORT_DOWN] = 1'b1;
        end else begin
          req[router_pkg::PORT_UP] = 1'b1;
        end
      end else begin
        // Arrived, flit goes out untouched
        req[router_pkg::PORT_NIC] = 1'b1;
      end
    end
  end

  // Only the requested output can return a ready
  // Masking keeps a stray bit from popping the buffer
  assign pop = |(req & out_ready);

endmodule

//--- source/output_port.sv
/*
 * Router output port
 * Arbitrates among the five inputs and buffers the winner for the link
 */
module output_port (
  input  logic                                        clk,
  input  logic                                        reset,
  // Requests for this output, bit i from input i
  input  router_pkg::port_mask_t                      req,
  // Routed flits of all inputs
  input  flit_pkg::flit_t [router_pkg::NUM_PORTS-1:0] in_flits,
  // Bit i high when input i hands over its flit
  output router_pkg::port_mask_t                      grant_ready,
  // Link to the neighbour or the core
  output flit_pkg::link_t                             out_link,
  input  logic                                        out_ready
);

  // Arbiter result
  router_pkg::port_mask_t grant;

  // Binary index of the winner
  router_pkg::port_idx_t grant_idx;

  // Winning flit
  flit_pkg::flit_t sel_flit;

  // Output buffer has room this cycle
  logic buf_ready;

  // Winner moves into the output buffer
  logic push;

  // --------------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------------
  // Pointer only moves when the winner really leaves its input
  rr_arbiter i_arbiter (
    .clk     (clk),
    .reset   (reset),
    .request (req),
    .advance (push),
    .grant   (grant)
  );

  // One-hot grant to index
  always_comb begin
    grant_idx = '0;
    for (int p = 0; p < router_pkg::NUM_PORTS; p++) begin
      if (grant[p]) begin
        grant_idx = router_pkg::port_idx_t'(p);
      end
    end
  end

  // Index never passes the last port while a grant is up
  assign sel_flit = in_flits[grant_idx];

  assign push = (|grant) & buf_ready;

  // Ready back to the winner only, and only when it is taken now
  assign grant_ready = grant & {router_pkg::NUM_PORTS{buf_ready}};

  // --------------------------------------------------------------------------
  // Output buffer
  // --------------------------------------------------------------------------
  // Valid from the edge of the push
  // Held flit stays put while the link is stalled
  flit_buffer i_out_buf (
    .clk       (clk),
    .reset     (reset),
    .in_flit   (sel_flit),
    .in_valid  (push),
    .in_ready  (buf_ready),
    .out_ready (out_ready),
    .out_valid (out_link.valid),
    .out_flit  (out_link.flit)
  );

endmodule

//--- source/router_pkg.sv
/*
 * Router organisation
 * Port count, port numbering and the per-port vector types
 */
package router_pkg;

  // --------------------------------------------------------------------------
  // Port count
  // --------------------------------------------------------------------------

  // Four mesh neighbours plus the local network interface
  localparam int NUM_PORTS = 5;

  // Index of one port
  typedef logic [2:0] port_idx_t;

  // One bit per port
  // Used for requests, grants and readies
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // --------------------------------------------------------------------------
  // Port numbering
  // --------------------------------------------------------------------------

  // The same index names an input and the output on that side
  localparam port_idx_t PORT_UP = 3'd0;

  localparam port_idx_t PORT_DOWN = 3'd1;

  localparam port_idx_t PORT_LEFT = 3'd2;

  localparam port_idx_t PORT_RIGHT = 3'd3;

  // Local delivery, also the injection point of the core
  localparam port_idx_t PORT_NIC = 3'd4;

  // Round-robin order follows the index
  // Lowest index wins right after reset

endpackage

//--- source/router_top.sv
/*
 * Five-port mesh router
 * Input ports and output ports joined by a full 5x5 crossbar
 */
module router_top (
  input  logic                                        clk,
  input  logic                                        reset,
  // Incoming links, indexed by port
  input  flit_pkg::link_t [router_pkg::NUM_PORTS-1:0] in_link,
  output router_pkg::port_mask_t                      in_ready,
  // Outgoing links, indexed by port
  output flit_pkg::link_t [router_pkg::NUM_PORTS-1:0] out_link,
  input  router_pkg::port_mask_t                      out_ready
);

  // --------------------------------------------------------------------------
  // Crossbar nets
  // --------------------------------------------------------------------------

  // Seen from the inputs, bit j names output j
  router_pkg::port_mask_t in_req [router_pkg::NUM_PORTS];

  // Readies collected per input, bit j from output j
  router_pkg::port_mask_t in_xbar_ready [router_pkg::NUM_PORTS];

  // Seen from the outputs, bit i names input i
  router_pkg::port_mask_t out_req [router_pkg::NUM_PORTS];

  // Grant readies per output, bit i to input i
  router_pkg::port_mask_t out_grant_ready [router_pkg::NUM_PORTS];

  // Routed flits, shared by all outputs
  flit_pkg::flit_t [router_pkg::NUM_PORTS-1:0] fwd_flits;

  // --------------------------------------------------------------------------
  // Input ports
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < router_pkg::NUM_PORTS; i++) begin : g_input
    input_port i_input_port (
      .clk       (clk),
      .reset     (reset),
      .in_link   (in_link[i]),
      .in_ready  (in_ready[i]),
      .out_ready (in_xbar_ready[i]),
      .req       (in_req[i]),
      .fwd_flit  (fwd_flits[i])
    );
  end

  // --------------------------------------------------------------------------
  // Transpose
  // --------------------------------------------------------------------------
  // Request i->j lands at output j, its ready goes back to input i
  // Full crossbar, a flit may leave on the side it came from
  for (genvar i = 0; i < router_pkg::NUM_PORTS; i++) begin : g_xbar_in
    for (genvar j = 0; j < router_pkg::NUM_PORTS; j++) begin : g_xbar_out
      assign out_req[j][i]       = in_req[i][j];
      assign in_xbar_ready[i][j] = out_grant_ready[j][i];
    end
  end

  // --------------------------------------------------------------------------
  // Output ports
  // --------------------------------------------------------------------------
  for (genvar j = 0; j < router_pkg::NUM_PORTS; j++) begin : g_output
    output_port i_output_port (
      .clk         (clk),
      .reset       (reset),
      .req         (out_req[j]),
      .in_flits    (fwd_flits),
      .grant_ready (out_grant_ready[j]),
      .out_link    (out_link[j]),
      .out_ready   (out_ready[j])
    );
  end

endmodule

//--- source/rr_arbiter.sv
/*
 * Five-way round-robin arbiter
 * One-hot grant from a rotating pointer, pointer moves on accepted grants
 */
module rr_arbiter (
  input  logic                   clk,
  input  logic                   reset,
  input  router_pkg::port_mask_t request,
  // Granted flit was taken this cycle
  input  logic                   advance,
  output router_pkg::port_mask_t grant
);

  // One-hot priority pointer
  // The port it marks wins first
  router_pkg::port_mask_t ptr;

  // --------------------------------------------------------------------------
  // Grant search
  // --------------------------------------------------------------------------
  // Start at the pointer, walk upwards, wrap past the last port
  always_comb begin : grant_search
    int unsigned idx;
    logic        found;

    grant = '0;
    found = 1'b0;
    idx   = 0;
    for (int base = 0; base < router_pkg::NUM_PORTS; base++) begin
      if (ptr[base]) begin
        for (int off = 0; off < router_pkg::NUM_PORTS; off++) begin
          idx = (base + off) % router_pkg::NUM_PORTS;
          // First requester on the way wins
          if (!found && request[idx]) begin
            grant[idx] = 1'b1;
            found      = 1'b1;
          end
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Pointer
  // --------------------------------------------------------------------------
  // Moves to the port after the winner
  // Held while the grant waits for room downstream
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr <= router_pkg::port_mask_t'(1);
    end else if (advance && (|grant)) begin
      // Rotate the one-hot grant up by one
      ptr <= {grant[router_pkg::NUM_PORTS-2:0], grant[router_pkg::NUM_PORTS-1]};
    end
  end

endmodule

//--- tb.f
source/flit_pkg.sv
source/router_pkg.sv
source/flit_buffer.sv
source/rr_arbiter.sv
source/input_port.sv
source/output_port.sv
source/router_top.sv
verification/router_tb.sv

//--- verification/router_tb.sv
/*
 * Self-checking testbench for the five-port mesh router
 * Directed table, round robin, back-pressure and LFSR traffic against a scoreboard
 */
module router_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP = router_pkg::NUM_PORTS;

  // One directed case, the flit fields plus the ready pattern and the exit port
  typedef struct packed {
    router_pkg::port_idx_t  src;
    logic                   x_dir;
    logic                   y_dir;
    flit_pkg::hop_t         hop_x;
    flit_pkg::hop_t         hop_y;
    router_pkg::port_mask_t ready;
    router_pkg::port_idx_t  exp_port;
  } row_t;

  localparam int NUM_ROWS = 8;

  // Budget per table row plus the random phase
  localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 300;

  // Ready bits run nic, right, left, down, up from the left
  localparam row_t ROWS [NUM_ROWS] = '{
    '{router_pkg::PORT_NIC,   1'b0, 1'b0, 4'd2, 4'd0, 5'b11111, router_pkg::PORT_RIGHT},
    '{router_pkg::PORT_NIC,   1'b1, 1'b0, 4'd1, 4'd0, 5'b11111, router_pkg::PORT_LEFT},
    '{router_pkg::PORT_UP,    1'b0, 1'b0, 4'd3, 4'd2, 5'b11111, router_pkg::PORT_RIGHT},
    '{router_pkg::PORT_DOWN,  1'b1, 1'b1, 4'd1, 4'd1, 5'b11111, router_pkg::PORT_LEFT},
    '{router_pkg::PORT_LEFT,  1'b0, 1'b0, 4'd0, 4'd2, 5'b11111, router_pkg::PORT_UP},
    '{router_pkg::PORT_RIGHT, 1'b0, 1'b1, 4'd0, 4'd1, 5'b00010, router_pkg::PORT_DOWN},
    '{router_pkg::PORT_UP,    1'b0, 1'b0, 4'd0, 4'd0, 5'b11111, router_pkg::PORT_NIC},
    // Leaves on the side it came in, full crossbar
    '{router_pkg::PORT_RIGHT, 1'b0, 1'b0, 4'd1, 4'd0, 5'b01000, router_pkg::PORT_RIGHT}
  };

  logic                     clk;
  logic                     reset;
  flit_pkg::link_t [NP-1:0] in_link;
  router_pkg::port_mask_t   in_ready;
  flit_pkg::link_t [NP-1:0] out_link;
  router_pkg::port_mask_t   out_ready;

  // --------------------------------------------------------------------------
  // Scoreboard state
  // --------------------------------------------------------------------------

  // Flits waiting to enter, per input
  flit_pkg::flit_t send_q [NP][$];
  // Expected flits per source and output, index src * NP + out
  flit_pkg::flit_t exp_q [NP*NP][$];
  int pending = 0;
  int accept_cnt [NP];
  int errors = 0;
  int checks = 0;
  int seq_num = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int unsigned cycle_count = 0;
  router_pkg::port_idx_t last_port;
  // Source order seen at the nic output
  router_pkg::port_idx_t nic_order [$];
  // Outputs stalled at the last edge, with the flit they showed
  logic [NP-1:0] held = '0;
  flit_pkg::flit_t held_flit [NP];
  logic [31:0] lfsr;

  router_top i_router_top (
    .clk       (clk),
    .reset     (reset),
    .in_link   (in_link),
    .in_ready  (in_ready),
    .out_link  (out_link),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  // Payload holds the source in bits 42:40 and a sequence number below
  function automatic flit_pkg::flit_t make_flit(input router_pkg::port_idx_t src,
      input logic xd, input logic yd, input flit_pkg::hop_t hx, input flit_pkg::hop_t hy);
    flit_pkg::flit_t f;
    f         = '0;
    f.x_dir   = xd;
    f.y_dir   = yd;
    f.hop_x   = hx;
    f.hop_y   = hy;
    f.payload = {5'd0, src, 8'h00, seq_num};
    seq_num++;
    return f;
  endfunction

  // One hop of dimension-order routing, X first, then Y, then local
  function automatic void route_model(input flit_pkg::flit_t f,
      output router_pkg::port_idx_t dst, output flit_pkg::flit_t nf);
    nf = f;
    if (f.hop_x != 4'd0) begin
      nf.hop_x = f.hop_x - 4'd1;
      dst      = f.x_dir ? router_pkg::PORT_LEFT : router_pkg::PORT_RIGHT;
    end else if (f.hop_y != 4'd0) begin
      nf.hop_y = f.hop_y - 4'd1;
      dst      = f.y_dir ? router_pkg::PORT_DOWN : router_pkg::PORT_UP;
    end else begin
      dst = router_pkg::PORT_NIC;
    end
  endfunction

  task automatic note_mismatch(input string msg);
    errors++;
    $display("[FAIL] %0d ns: %s", $time, msg);
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("Error at %0d ns: %s", $time, msg);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // Head of each send queue goes on the link
  task automatic drive_inputs();
    for (int p = 0; p < NP; p++) begin
      in_link[p].valid = (send_q[p].size() != 0);
      in_link[p].flit  = (send_q[p].size() != 0) ? send_q[p][0] : '0;
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    drive_inputs();
  endtask

  task automatic send(input int p, input flit_pkg::flit_t f);
    send_q[p].push_back(f);
    drive_inputs();
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) next_cycle();
    reset = 1'b0;
  endtask

  // Until every flit is in and every expected flit is out
  task automatic wait_drain();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      next_cycle();
      busy = (pending != 0);
      for (int p = 0; p < NP; p++) begin
        if (send_q[p].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitor
  // --------------------------------------------------------------------------

  task automatic record_accept(input int p);
    router_pkg::port_idx_t dst;
    flit_pkg::flit_t       nf;
    route_model(in_link[p].flit, dst, nf);
    exp_q[p * NP + int'(dst)].push_back(nf);
    void'(send_q[p].pop_front());
    pending++;
    accept_cnt[p]++;
  endtask

  task automatic check_delivery(input int q);
    flit_pkg::flit_t got;
    flit_pkg::flit_t want;
    int              src;
    got = out_link[q].flit;
    src = int'(got.payload[42:40]);
    if (src >= NP || exp_q[src * NP + q].size() == 0) begin
      note_error($sformatf("output %0d delivered a flit nobody sent, source %0d", q, src));
    end else begin
      want = exp_q[src * NP + q].pop_front();
      pending--;
      checks++;
      if (got !== want) begin
        note_mismatch($sformatf("output %0d from %0d got %h want %h", q, src, got, want));
      end
    end
    last_port = router_pkg::port_idx_t'(q);
    if (q == router_pkg::PORT_NIC) begin
      nic_order.push_back(router_pkg::port_idx_t'(src));
    end
  endtask

  // Values before the edge, the DUT flops update later in the step
  always @(posedge clk) begin
    if (!reset) begin
      for (int p = 0; p < NP; p++) begin
        if (in_link[p].valid && in_ready[p]) begin
          record_accept(p);
        end
      end
      for (int q = 0; q < NP; q++) begin
        // A stalled output keeps valid and flit
        if (held[q]) begin
          checks++;
          if (!out_link[q].valid || out_link[q].flit !== held_flit[q]) begin
            note_mismatch($sformatf("output %0d changed while stalled", q));
          end
        end
        if (out_link[q].valid && out_ready[q]) begin
          check_delivery(q);
        end
        held[q]      = out_link[q].valid && !out_ready[q];
        held_flit[q] = out_link[q].flit;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int             err0;
    logic           xd;
    logic           yd;
    flit_pkg::hop_t hx;
    flit_pkg::hop_t hy;

    reset     = 1'b1;
    in_link   = '0;
    out_ready = '1;
    lfsr      = 32'h2dcce53e;
    for (int p = 0; p < NP; p++) begin
      accept_cnt[p] = 0;
    end
    apply_reset();

    // Idle outputs, open inputs
    err0 = errors;
    for (int p = 0; p < NP; p++) begin
      checks++;
      if (out_link[p].valid !== 1'b0) begin
        note_mismatch($sformatf("output %0d valid right after reset", p));
      end
    end
    checks++;
    if (in_ready !== 5'b11111) begin
      note_mismatch($sformatf("in_ready %b right after reset", in_ready));
    end
    end_test("reset", err0);

    // Directed table, one flit per row
    for (int r = 0; r < NUM_ROWS; r++) begin
      err0 = errors;
      next_cycle();
      out_ready = ROWS[r].ready;
      send(int'(ROWS[r].src), make_flit(ROWS[r].src, ROWS[r].x_dir, ROWS[r].y_dir,
                                        ROWS[r].hop_x, ROWS[r].hop_y));
      wait_drain();
      checks++;
      if (last_port !== ROWS[r].exp_port) begin
        note_mismatch($sformatf("row %0d left at %0d, want %0d", r, last_port,
                                ROWS[r].exp_port));
      end
      end_test($sformatf("row %0d", r), err0);
    end
    out_ready = '1;

    // Round robin at the nic output, pointer back at up
    apply_reset();
    err0 = errors;
    nic_order.delete();
    next_cycle();
    send(router_pkg::PORT_UP, make_flit(router_pkg::PORT_UP, 1'b0, 1'b0, 4'd0, 4'd0));
    send(router_pkg::PORT_LEFT, make_flit(router_pkg::PORT_LEFT, 1'b0, 1'b0, 4'd0, 4'd0));
    send(router_pkg::PORT_NIC, make_flit(router_pkg::PORT_NIC, 1'b0, 1'b0, 4'd0, 4'd0));
    // Second burst queued right behind the first
    // Up refills as soon as it wins and requests again next cycle
    // Rotation hands the next grants to left and nic before up comes back
    send(router_pkg::PORT_LEFT, make_flit(router_pkg::PORT_LEFT, 1'b0, 1'b0, 4'd0, 4'd0));
    send(router_pkg::PORT_UP, make_flit(router_pkg::PORT_UP, 1'b0, 1'b0, 4'd0, 4'd0));
    wait_drain();
    checks++;
    if (nic_order.size() != 5 || nic_order[0] != router_pkg::PORT_UP ||
        nic_order[1] != router_pkg::PORT_LEFT || nic_order[2] != router_pkg::PORT_NIC ||
        nic_order[3] != router_pkg::PORT_UP || nic_order[4] != router_pkg::PORT_LEFT) begin
      note_mismatch($sformatf("nic order %p, want up left nic up left", nic_order));
    end
    end_test("round robin", err0);

    // Right output stalled, nic feeds it four flits
    err0 = errors;
    accept_cnt[router_pkg::PORT_NIC] = 0;
    next_cycle();
    out_ready = 5'b10111;
    for (int n = 0; n < 4; n++) begin
      send(router_pkg::PORT_NIC, make_flit(router_pkg::PORT_NIC, 1'b0, 1'b0, 4'd1, 4'd0));
    end
    // Steady state, one flit in each buffer on the path
    repeat (8) next_cycle();
    checks++;
    if (accept_cnt[router_pkg::PORT_NIC] != 2) begin
      note_mismatch($sformatf("nic accepted %0d flits under stall, want 2",
                              accept_cnt[router_pkg::PORT_NIC]));
    end
    checks++;
    if (in_ready[router_pkg::PORT_NIC] !== 1'b0 ||
        out_link[router_pkg::PORT_RIGHT].valid !== 1'b1) begin
      note_mismatch("nic in_ready high or right output empty under stall");
    end
    next_cycle();
    out_ready = '1;
    wait_drain();
    checks++;
    if (accept_cnt[router_pkg::PORT_NIC] != 4) begin
      note_mismatch($sformatf("nic accepted %0d flits in all, want 4",
                              accept_cnt[router_pkg::PORT_NIC]));
    end
    end_test("back-pressure", err0);

    // LFSR traffic with random readies
    err0 = errors;
    for (int c = 0; c < 150; c++) begin
      next_cycle();
      out_ready = router_pkg::port_mask_t'(random_bits(5));
      for (int p = 0; p < NP; p++) begin
        if (send_q[p].size() < 2 && random_bits(1) == 8'd1) begin
          xd = random_bits(1) != 8'd0;
          yd = random_bits(1) != 8'd0;
          hx = flit_pkg::hop_t'(random_bits(2));
          hy = flit_pkg::hop_t'(random_bits(2));
          send(p, make_flit(router_pkg::port_idx_t'(p), xd, yd, hx, hy));
        end
      end
    end
    next_cycle();
    out_ready = '1;
    wait_drain();
    // Every flit is out, so a valid output now would be a duplicate
    for (int p = 0; p < NP; p++) begin
      checks++;
      if (out_link[p].valid !== 1'b0) begin
        note_mismatch($sformatf("output %0d still valid after the last flit", p));
      end
    end
    end_test("random traffic", err0);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
